//--- flist.f
+incdir+source
source/alu_pkg.sv
source/alu_credit_fifo.sv
source/alu_adder_unit.sv
source/alu_bit_counter.sv
source/alu_logic_shift_unit.sv
source/alu_exec_stage.sv
source/alu_core_top.sv
tb/alu_core_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module alu_core_top_tb -o alu_sim \
  || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/alu_sim)"
echo "$sim_out"

echo "$sim_out" | grep -q "TESTS PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- source/alu_adder_unit.sv
`include "alu_defines.svh"

module alu_adder_unit (
  input  logic [`ALU_DATA_W-1:0] a,
  input  logic [`ALU_DATA_W-1:0] b,
  input  alu_pkg::alu_op_e       op,
  output logic [`ALU_DATA_W-1:0] sum,
  output logic [`ALU_DATA_W-1:0] set_res
);

  localparam int W = `ALU_DATA_W;

  logic         invb;
  logic [W-1:0] addend;
  logic         cf;
  logic         of;
  logic         lt;

  // sub and both compares take a + ~b + 1
  assign invb = (op == alu_pkg::op_sub) || (op == alu_pkg::op_slt) ||
                (op == alu_pkg::op_sltu);
  assign addend = invb ? ~b : b;

  assign {cf, sum} = {1'b0, a} + {1'b0, addend} + (W + 1)'(invb);

  // carry into msb differs from carry out
  assign of = a[W-1] ^ addend[W-1] ^ sum[W-1] ^ cf;

  // no borrow out means a >= b unsigned
  assign lt = (op == alu_pkg::op_slt) ? (sum[W-1] ^ of) : ~cf;

  assign set_res = {{(W - 1){1'b0}}, lt};

endmodule

//--- source/alu_bit_counter.sv
module alu_bit_counter #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]       value,
  input  logic                   count_ones,
  output logic [$clog2(WIDTH):0] count
);

  localparam int HALF   = WIDTH / 2;
  localparam int HALF_W = $clog2(WIDTH);

  generate
    if (WIDTH == 4) begin : g_leaf
      logic [3:0] bits;

      // look for ones either way
      assign bits = count_ones ? value : ~value;

      assign count = (bits == 4'b1111)      ? 3'd4 :
                     (bits[3:1] == 3'b111)  ? 3'd3 :
                     (bits[3:2] == 2'b11)   ? 3'd2 :
                     bits[3]                ? 3'd1 :
                                              3'd0;
    end else begin : g_node
      logic [HALF_W-1:0] cnt_hi;
      logic [HALF_W-1:0] cnt_lo;

      alu_bit_counter #(.WIDTH(HALF)) u_hi (
        .value      (value[WIDTH-1:HALF]),
        .count_ones (count_ones),
        .count      (cnt_hi)
      );

      alu_bit_counter #(.WIDTH(HALF)) u_lo (
        .value      (value[HALF-1:0]),
        .count_ones (count_ones),
        .count      (cnt_lo)
      );

      // low half only continues a run that fills the high half
      assign count = (cnt_hi == HALF_W'(HALF)) ? {1'b0, cnt_hi} + {1'b0, cnt_lo}
                                               : {1'b0, cnt_hi};
    end
  endgenerate

endmodule

//--- source/alu_core_top.sv
`include "alu_defines.svh"

module alu_core_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              op_valid,
  input  alu_pkg::alu_req_t op_data,
  output logic              op_credit,
  output logic              rsp_valid,
  output alu_pkg::alu_rsp_t rsp_data,
  input  logic              rsp_credit
);

  logic              exec_in_valid;
  alu_pkg::alu_req_t exec_in_req;
  logic              exec_out_valid;
  alu_pkg::alu_rsp_t exec_out_rsp;
  logic              out_credit_ret;

  // input hop spends output-hop credits end to end
  alu_credit_fifo #(
    .item_t  (alu_pkg::alu_req_t),
    .DEPTH   (`ALU_IN_DEPTH),
    .CREDITS (`ALU_OUT_DEPTH)
  ) u_req_in (
    .clk (clk), .rst_n (rst_n),
    .in_valid (op_valid), .in_data (op_data), .credit_up (op_credit),
    .out_valid (exec_in_valid), .out_data (exec_in_req), .credit_down (out_credit_ret)
  );

  alu_exec_stage u_exec (
    .clk (clk), .rst_n (rst_n),
    .in_valid (exec_in_valid), .in_req (exec_in_req),
    .out_valid (exec_out_valid), .out_rsp (exec_out_rsp)
  );

  alu_credit_fifo #(
    .item_t  (alu_pkg::alu_rsp_t),
    .DEPTH   (`ALU_OUT_DEPTH),
    .CREDITS (`ALU_RSP_CREDITS)
  ) u_rsp_out (
    .clk (clk), .rst_n (rst_n),
    .in_valid (exec_out_valid), .in_data (exec_out_rsp), .credit_up (out_credit_ret),
    .out_valid (rsp_valid), .out_data (rsp_data), .credit_down (rsp_credit)
  );

endmodule

//--- source/alu_credit_fifo.sv
module alu_credit_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH   = 4,
  parameter int  CREDITS = 2
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  item_t in_data,
  output logic  credit_up,
  output logic  out_valid,
  output item_t out_data,
  input  logic  credit_down
);

  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = $clog2(CREDITS + 1);

  item_t             mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  fill;
  logic [CRED_W-1:0] credits;
  logic              pop;

  // send only when something is held and downstream has room
  assign pop = (fill != '0) && (credits != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      credits   <= CRED_W'(CREDITS);
      out_valid <= 1'b0;
      credit_up <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill      <= fill + CNT_W'(in_valid) - CNT_W'(pop);
      credits   <= credits + CRED_W'(credit_down) - CRED_W'(pop);
      out_valid <= pop;
      // hand a credit back upstream for the freed slot
      credit_up <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
    if (pop) begin
      out_data <= mem[rd_ptr];
    end
  end

endmodule

//--- source/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// operand and result width
`define ALU_DATA_W 32

// shift amount taken from b
`define ALU_SHAMT_W 5

// count result must hold the value 32
`define ALU_CNT_W 6

// input buffer depth and the sender's starting credits
`define ALU_IN_DEPTH 4

// output buffer depth and the input hop's starting credits
`define ALU_OUT_DEPTH 2

// credits the output hop starts with toward the sink
`define ALU_RSP_CREDITS 2

`endif

//--- source/alu_exec_stage.sv
`include "alu_defines.svh"

module alu_exec_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  alu_pkg::alu_req_t in_req,
  output logic              out_valid,
  output alu_pkg::alu_rsp_t out_rsp
);

  logic [`ALU_DATA_W-1:0] sum;
  logic [`ALU_DATA_W-1:0] set_res;
  logic [`ALU_DATA_W-1:0] ls_res;
  logic [`ALU_DATA_W-1:0] result;
  logic                   is_add_sub;
  logic                   is_set;

  alu_adder_unit u_adder (
    .a       (in_req.a),
    .b       (in_req.b),
    .op      (in_req.op),
    .sum     (sum),
    .set_res (set_res)
  );

  alu_logic_shift_unit u_logic_shift (
    .a          (in_req.a),
    .b          (in_req.b),
    .op         (in_req.op),
    .count_ones (in_req.count_ones),
    .result     (ls_res)
  );

  assign is_add_sub = (in_req.op == alu_pkg::op_add) || (in_req.op == alu_pkg::op_sub);
  assign is_set     = (in_req.op == alu_pkg::op_slt) || (in_req.op == alu_pkg::op_sltu);

  // result select
  always_comb begin
    if (is_add_sub) begin
      result = sum;
    end else if (is_set) begin
      result = set_res;
    end else begin
      result = ls_res;
    end
  end

  // never stalls since the output slot is already owned
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_rsp.result <= result;
    out_rsp.zero   <= (result == '0);
  end

endmodule

//--- source/alu_logic_shift_unit.sv
`include "alu_defines.svh"

module alu_logic_shift_unit (
  input  logic [`ALU_DATA_W-1:0] a,
  input  logic [`ALU_DATA_W-1:0] b,
  input  alu_pkg::alu_op_e       op,
  input  logic                   count_ones,
  output logic [`ALU_DATA_W-1:0] result
);

  localparam int W = `ALU_DATA_W;

  logic [`ALU_SHAMT_W-1:0] shamt;
  logic [2*W-1:0]          sr_tmp;
  logic [2*W-1:0]          rot_tmp;
  logic [W-1:0]            bit_rev;
  logic [W-1:0]            byte_rev;
  logic [W-1:0]            cnt_in;
  logic [`ALU_CNT_W-1:0]   cnt_res;
  logic [W-1:0]            cnt_ext;

  assign shamt = b[`ALU_SHAMT_W-1:0];

  // upper half carries the sign for sra
  assign sr_tmp  = {{W{(op == alu_pkg::op_sra) & a[W-1]}}, a} >> shamt;
  assign rot_tmp = {a, a} >> shamt;

  always_comb begin
    for (int i = 0; i < W; i++) begin
      bit_rev[i] = a[W-1-i];
    end
  end

  assign byte_rev = {a[7:0], a[15:8], a[23:16], a[31:24]};

  // trailing count runs the leading counter on the mirrored word
  assign cnt_in = (op == alu_pkg::op_count_t) ? bit_rev : a;

  alu_bit_counter #(.WIDTH(`ALU_DATA_W)) u_counter (
    .value      (cnt_in),
    .count_ones (count_ones),
    .count      (cnt_res)
  );

  assign cnt_ext = {{(W - `ALU_CNT_W){1'b0}}, cnt_res};

  always_comb begin
    case (op)
      alu_pkg::op_and:     result = a & b;
      alu_pkg::op_or:      result = a | b;
      alu_pkg::op_xor:     result = a ^ b;
      alu_pkg::op_nor:     result = ~(a | b);
      alu_pkg::op_andn:    result = a & ~b;
      alu_pkg::op_orn:     result = a | ~b;
      alu_pkg::op_sll:     result = a << shamt;
      alu_pkg::op_srl,
      alu_pkg::op_sra:     result = sr_tmp[W-1:0];
      alu_pkg::op_rotr:    result = rot_tmp[W-1:0];
      alu_pkg::op_count_l,
      alu_pkg::op_count_t: result = cnt_ext;
      alu_pkg::op_bitrev:  result = bit_rev;
      alu_pkg::op_revb:    result = byte_rev;
      alu_pkg::op_seb:     result = {{(W - 8){a[7]}}, a[7:0]};
      alu_pkg::op_seh:     result = {{(W - 16){a[15]}}, a[15:0]};
      // arithmetic ops come from the adder
      default:             result = '0;
    endcase
  end

endmodule

//--- source/alu_pkg.sv
`include "alu_defines.svh"

package alu_pkg;

  typedef enum logic [4:0] {
    op_add     = 5'd0,
    op_sub     = 5'd1,
    op_slt     = 5'd2,
    op_sltu    = 5'd3,
    op_and     = 5'd4,
    op_or      = 5'd5,
    op_xor     = 5'd6,
    op_nor     = 5'd7,
    op_andn    = 5'd8,
    op_orn     = 5'd9,
    op_sll     = 5'd10,
    op_srl     = 5'd11,
    op_sra     = 5'd12,
    op_rotr    = 5'd13,
    op_count_l = 5'd14,
    op_count_t = 5'd15,
    op_bitrev  = 5'd16,
    op_revb    = 5'd17,
    op_seb     = 5'd18,
    op_seh     = 5'd19
  } alu_op_e;

  typedef struct packed {
    alu_op_e                op;
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;
    // selects counting of ones instead of zeros
    logic                   count_ones;
  } alu_req_t;

  typedef struct packed {
    logic [`ALU_DATA_W-1:0] result;
    logic                   zero;
  } alu_rsp_t;

endpackage

//--- tb/alu_core_top_tb.sv
`include "alu_defines.svh"

module alu_core_top_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_REQ    = 400;
  localparam int MAX_CYCLES = NUM_REQ * 12 + 200;
  localparam int NUM_OPS    = 20;

  logic              clk;
  logic              rst_n;
  logic              op_valid;
  alu_pkg::alu_req_t op_data;
  logic              op_credit;
  logic              rsp_valid;
  alu_pkg::alu_rsp_t rsp_data;
  logic              rsp_credit;

  alu_pkg::alu_req_t stim_q[$];
  alu_pkg::alu_req_t req_q[$];
  alu_pkg::alu_rsp_t exp_q[$];
  alu_pkg::alu_req_t got_req;
  alu_pkg::alu_rsp_t exp_rsp;

  int   errors         = 0;
  int   checks         = 0;
  int   cycles         = 0;
  int   sent           = 0;
  int   received       = 0;
  int   in_credits     = `ALU_IN_DEPTH;
  int   in_credit_seen = 0;
  int   rsp_seen       = 0;
  int   rsp_returned   = 0;
  int   pending        = 0;
  int   sink_cycle     = 0;
  logic run            = 1'b0;

  alu_core_top alu_core_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_valid   (op_valid),
    .op_data    (op_data),
    .op_credit  (op_credit),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_credit (rsp_credit)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
  end

  function automatic alu_pkg::alu_req_t make_req(alu_pkg::alu_op_e op,
                                                 logic [`ALU_DATA_W-1:0] a,
                                                 logic [`ALU_DATA_W-1:0] b, logic ones);
    alu_pkg::alu_req_t r;
    r.op         = op;
    r.a          = a;
    r.b          = b;
    r.count_ones = ones;
    return r;
  endfunction

  // corner values show up often
  function automatic logic [`ALU_DATA_W-1:0] rand_operand();
    int mode;
    mode = int'($urandom % 8);
    case (mode)
      0:       return '0;
      1:       return '1;
      2:       return `ALU_DATA_W'($urandom % 64);
      default: return `ALU_DATA_W'($urandom);
    endcase
  endfunction

  function automatic alu_pkg::alu_req_t rand_req();
    alu_pkg::alu_op_e op;
    op = alu_pkg::alu_op_e'(5'($urandom % NUM_OPS));
    return make_req(op, rand_operand(), rand_operand(), 1'($urandom % 2));
  endfunction

  // expected response from the operation rules
  function automatic alu_pkg::alu_rsp_t alu_ref(alu_pkg::alu_req_t req);
    alu_pkg::alu_rsp_t      rsp;
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;
    logic [`ALU_DATA_W-1:0] r;
    int                     sh;
    int                     n;
    logic                   run_on;
    a      = req.a;
    b      = req.b;
    sh     = int'(b[4:0]);
    r      = '0;
    n      = 0;
    run_on = 1'b1;
    case (req.op)
      alu_pkg::op_add:  r = a + b;
      alu_pkg::op_sub:  r = a - b;
      alu_pkg::op_slt:  r = ($signed(a) < $signed(b)) ? `ALU_DATA_W'(1) : '0;
      alu_pkg::op_sltu: r = (a < b) ? `ALU_DATA_W'(1) : '0;
      alu_pkg::op_and:  r = a & b;
      alu_pkg::op_or:   r = a | b;
      alu_pkg::op_xor:  r = a ^ b;
      alu_pkg::op_nor:  r = ~(a | b);
      alu_pkg::op_andn: r = a & ~b;
      alu_pkg::op_orn:  r = a | ~b;
      alu_pkg::op_sll:  r = a << sh;
      alu_pkg::op_srl:  r = a >> sh;
      alu_pkg::op_sra:  r = $unsigned($signed(a) >>> sh);
      alu_pkg::op_rotr: begin
        for (int i = 0; i < `ALU_DATA_W; i++) begin
          r[i] = a[(i + sh) % `ALU_DATA_W];
        end
      end
      alu_pkg::op_count_l: begin
        for (int i = `ALU_DATA_W - 1; i >= 0; i--) begin
          if (a[i] != req.count_ones) begin
            run_on = 1'b0;
          end
          if (run_on) begin
            n++;
          end
        end
        r = `ALU_DATA_W'(n);
      end
      alu_pkg::op_count_t: begin
        for (int i = 0; i < `ALU_DATA_W; i++) begin
          if (a[i] != req.count_ones) begin
            run_on = 1'b0;
          end
          if (run_on) begin
            n++;
          end
        end
        r = `ALU_DATA_W'(n);
      end
      alu_pkg::op_bitrev: begin
        for (int i = 0; i < `ALU_DATA_W; i++) begin
          r[i] = a[`ALU_DATA_W-1-i];
        end
      end
      alu_pkg::op_revb: begin
        for (int i = 0; i < 4; i++) begin
          r[8*i +: 8] = a[8*(3-i) +: 8];
        end
      end
      alu_pkg::op_seb: r = `ALU_DATA_W'($signed(a[7:0]));
      alu_pkg::op_seh: r = `ALU_DATA_W'($signed(a[15:0]));
      default:         r = '0;
    endcase
    rsp.result = r;
    rsp.zero   = (r == '0);
    return rsp;
  endfunction

  task automatic add_directed();
    alu_pkg::alu_op_e sh_ops[4];
    alu_pkg::alu_op_e lg_ops[6];
    sh_ops = '{alu_pkg::op_sll, alu_pkg::op_srl, alu_pkg::op_sra, alu_pkg::op_rotr};
    lg_ops = '{alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor, alu_pkg::op_nor,
               alu_pkg::op_andn, alu_pkg::op_orn};
    stim_q.push_back(make_req(alu_pkg::op_add, 32'hffff_ffff, 32'h0000_0001, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_add, 32'h7fff_ffff, 32'h0000_0001, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_sub, 32'h1234_5678, 32'h1234_5678, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_sub, 32'h0000_0000, 32'h0000_0001, 1'b0));
    // mixed signs split slt from sltu
    stim_q.push_back(make_req(alu_pkg::op_slt, 32'h8000_0000, 32'h0000_0001, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_sltu, 32'h8000_0000, 32'h0000_0001, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_slt, 32'h0000_0001, 32'hffff_ffff, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_sltu, 32'h0000_0001, 32'hffff_ffff, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_slt, 32'h0000_0005, 32'h0000_0005, 1'b0));
    foreach (sh_ops[k]) begin
      stim_q.push_back(make_req(sh_ops[k], 32'h8000_0001, 32'hffff_ffe0, 1'b0));
      stim_q.push_back(make_req(sh_ops[k], 32'h8000_0001, 32'h0000_001f, 1'b0));
    end
    foreach (lg_ops[k]) begin
      stim_q.push_back(make_req(lg_ops[k], 32'hffff_0000, 32'h0f0f_0f0f, 1'b0));
    end
    for (int ones = 0; ones < 2; ones++) begin
      stim_q.push_back(make_req(alu_pkg::op_count_l, '0, '0, 1'(ones)));
      stim_q.push_back(make_req(alu_pkg::op_count_l, '1, '0, 1'(ones)));
      stim_q.push_back(make_req(alu_pkg::op_count_t, '0, '0, 1'(ones)));
      stim_q.push_back(make_req(alu_pkg::op_count_t, '1, '0, 1'(ones)));
    end
    stim_q.push_back(make_req(alu_pkg::op_count_l, 32'h00ff_ffff, '0, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_count_t, 32'hffff_fff0, '0, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_bitrev, 32'h0000_0001, '0, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_revb, 32'h1234_5678, '0, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_seb, 32'h0000_0080, '0, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_seb, 32'h0000_007f, '0, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_seh, 32'h0000_8000, '0, 1'b0));
    stim_q.push_back(make_req(alu_pkg::op_seh, 32'h0001_7fff, '0, 1'b0));
  endtask

  task automatic check_quiet(string when);
    checks++;
    if (rsp_valid !== 1'b0 || op_credit !== 1'b0) begin
      errors++;
      $display("ERROR %0t: rsp_valid=%b op_credit=%b %s", $time, rsp_valid, op_credit, when);
    end
  endtask

  // sender spending credits of the input link
  always @(posedge clk) begin
    if (run) begin
      if (op_credit) begin
        in_credits++;
        in_credit_seen++;
      end
      checks++;
      if (in_credit_seen > sent) begin
        errors++;
        $display("ERROR %0t: %0d op_credit pulses for %0d requests", $time, in_credit_seen,
                 sent);
      end
      if (in_credits > 0 && sent < NUM_REQ && ($urandom % 4) != 0) begin
        op_valid <= 1'b1;
        op_data  <= stim_q[sent];
        req_q.push_back(stim_q[sent]);
        exp_q.push_back(alu_ref(stim_q[sent]));
        sent++;
        in_credits--;
      end else begin
        op_valid <= 1'b0;
      end
    end
  end

  // sink with random credit return and long stalls
  always @(posedge clk) begin
    if (run) begin
      sink_cycle++;
      if (rsp_valid) begin
        rsp_seen++;
        pending++;
      end
      checks++;
      if (rsp_seen > rsp_returned + `ALU_RSP_CREDITS) begin
        errors++;
        $display("ERROR %0t: %0d responses against %0d returned credits", $time, rsp_seen,
                 rsp_returned);
      end
      // last 120 cycles of every 500 hold credit back
      if (pending > 0 && (sink_cycle % 500) < 380 && ($urandom % 3) != 0) begin
        rsp_credit <= 1'b1;
        pending--;
        rsp_returned++;
      end else begin
        rsp_credit <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && rsp_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR %0t: response arrived with no request outstanding", $time);
      end else begin
        exp_rsp = exp_q.pop_front();
        got_req = req_q.pop_front();
        received++;
        checks += 2;
        if (rsp_data.result !== exp_rsp.result) begin
          errors++;
          $display("ERROR %0t: %s a=%h b=%h result %h, expected %h", $time,
                   got_req.op.name(), got_req.a, got_req.b, rsp_data.result, exp_rsp.result);
        end
        if (rsp_data.zero !== exp_rsp.zero) begin
          errors++;
          $display("ERROR %0t: %s a=%h b=%h zero %b, expected %b", $time,
                   got_req.op.name(), got_req.a, got_req.b, rsp_data.zero, exp_rsp.zero);
        end
      end
    end
  end

  initial begin
    void'($urandom(2832));
    clk        = 1'b0;
    rst_n      = 1'b0;
    op_valid   = 1'b0;
    op_data    = '0;
    rsp_credit = 1'b0;
    add_directed();
    while (stim_q.size() < NUM_REQ) begin
      stim_q.push_back(rand_req());
    end

    @(posedge clk);
    repeat (2) begin
      @(posedge clk);
      check_quiet("during reset");
    end
    rst_n <= 1'b1;
    repeat (2) begin
      @(posedge clk);
      check_quiet("right after reset");
    end
    run <= 1'b1;

    while ((received != NUM_REQ || in_credit_seen != NUM_REQ) && cycles < MAX_CYCLES) begin
      @(negedge clk);
    end
    if (received != NUM_REQ || in_credit_seen != NUM_REQ) begin
      errors++;
      $display("timeout after %0d cycles: %0d of %0d responses, %0d op credits returned",
               cycles, received, NUM_REQ, in_credit_seen);
    end else begin
      // short tail catches a stray extra response
      repeat (4) begin
        @(negedge clk);
      end
    end
    $display("checks=%0d errors=%0d sent=%0d received=%0d op_credits=%0d", checks, errors,
             sent, received, in_credit_seen);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
